//--- files.f
logic/tetris_pkg.sv
logic/grid_rows.sv
logic/grid_arbiter.sv
logic/piece_ctrl.sv
logic/row_clear.sv
logic/apb_grid_port.sv
logic/tetris_top.sv
testbench/frame_clock.sv
testbench/tetris_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is found in the log
verilator --binary --timing --top-module tetris_tb -f files.f -o tetris_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tetris_sim > sim.log 2>&1 ; cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/tetris_tb.sv
/* directed tests of the playfield engine, software grid model,
   value check and cycle timeout */
`timescale 1ns/1ns
`default_nettype none

module tetris_tb import tetris_pkg::*; ();

    localparam logic [31:0] RAND_SEED = 32'h8401_7759;
    localparam int GRAVITY_STEPS = 40;
    localparam int HARD_DROPS = 7;
    localparam int CYCLE_LIMIT = GRAVITY_STEPS * 64 + HARD_DROPS * 2000 + 20000;

    logic       frame_clk;
    logic       reset;
    logic [7:0] keycode;
    score_t     score;
    kind_t      next_block;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    row_t       pwdata;
    row_t       prdata;
    logic       pready;
    logic       pslverr;

    int          model_grid [GRID_ROWS][GRID_COLS];
    int          model_score;
    int          cycle_count = 0;
    logic [31:0] rnd;

    frame_clock u_clock (
        .frame_clk (frame_clk),
        .reset     (reset)
    );

    tetris_top uut (
        .frame_clk  (frame_clk),
        .reset      (reset),
        .keycode    (keycode),
        .score      (score),
        .next_block (next_block),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    always @(posedge frame_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d frames", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // ----------------------------------------
    // software grid model
    // ----------------------------------------
    function automatic bit box_cell(input int kind, input int r, input int c);
        case (kind)
            0: return r == 1;
            1: return (r == 0 && c == 1) || (r == 1 && c >= 1);
            2: return (r == 0 && c == 3) || (r == 1 && c >= 1);
            3: return c == 1 || c == 2;
            4: return (r == 0 && c >= 2) || (r == 1 && (c == 1 || c == 2));
            5: return (r == 0 && c == 2) || (r == 1 && c >= 1);
            default: return 1'b0;
        endcase
    endfunction

    function automatic bit piece_fits(input int kind, input int bx, input int by);
        int row;
        int col;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 4; c++) begin
                row = by + r;
                col = bx + c;
                if (box_cell(kind, r, c)) begin
                    if (col < 0 || col >= GRID_COLS || row >= GRID_ROWS) return 1'b0;
                    if (model_grid[row][col] != 7) return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic clear_model();
        int r;
        bit full;
        r = GRID_ROWS - 1;
        while (r >= 0) begin
            full = 1'b1;
            for (int c = 0; c < GRID_COLS; c++) begin
                if (model_grid[r][c] == 7) full = 1'b0;
            end
            if (full) begin
                for (int s = r; s > 0; s--) begin
                    for (int c = 0; c < GRID_COLS; c++) begin
                        model_grid[s][c] = model_grid[s-1][c];
                    end
                end
                for (int c = 0; c < GRID_COLS; c++) begin
                    model_grid[0][c] = 7;
                end
                model_score++;
            end else begin
                r--;
            end
        end
    endtask

    // lands the piece from the top of its column, then clears full rows
    task automatic lock_model(input int kind, input int bx);
        int y;
        y = 0;
        while (piece_fits(kind, bx, y + 1)) y++;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (box_cell(kind, r, c)) model_grid[y+r][bx+c] = kind;
            end
        end
        clear_model();
    endtask

    function automatic row_t expected_row(input int r);
        row_t v;
        for (int c = 0; c < GRID_COLS; c++) begin
            v[c*3 +: 3] = 3'(model_grid[r][c]);
        end
        return v;
    endfunction

    // ----------------------------------------
    // APB host and status helpers
    // ----------------------------------------
    task automatic apb_access(input logic write, input apb_addr_t a,
                              output row_t data, output logic err);
        @(negedge frame_clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = a;
        pwdata = 30'h0;
        @(negedge frame_clk);
        penable = 1'b1;
        do @(negedge frame_clk); while (!pready);
        data = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_status(output int row, output int col, output int kind);
        row_t data;
        logic err;
        apb_access(1'b0, ADDR_STATUS, data, err);
        row = int'(data[11:7]);
        col = int'(data[6:3]);
        kind = int'(data[2:0]);
    endtask

    task automatic wait_gravity_step();
        int row0, row, col, kind;
        read_status(row0, col, kind);
        do read_status(row, col, kind); while (row == row0);
    endtask

    // presses right after a gravity step, so the piece is idle
    task automatic press_key(input logic [7:0] code, input int hold);
        int gap;
        wait_gravity_step();
        gap = int'($urandom % 4) + 1;
        repeat (gap) @(negedge frame_clk);
        keycode = code;
        repeat (hold) @(negedge frame_clk);
        keycode = 8'h00;
        repeat (8) @(negedge frame_clk);
    endtask

    task automatic move_to(input int target);
        int row, col, kind, want;
        read_status(row, col, kind);
        while (col != target) begin
            want = (col < target) ? col + 1 : col - 1;
            press_key((col < target) ? KEY_RIGHT : KEY_LEFT, 3);
            read_status(row, col, kind);
            check_value(col, want, "column after a side move");
        end
    endtask

    task automatic compare_grid();
        row_t data;
        logic err;
        for (int r = 0; r < GRID_ROWS; r++) begin
            apb_access(1'b0, apb_addr_t'(r), data, err);
            check_value(data, expected_row(r), $sformatf("grid row %0d", r));
        end
        apb_access(1'b0, ADDR_SCORE, data, err);
        check_value(data, model_score, "score over APB");
        check_value(score, model_score, "score output");
    endtask

    task automatic drop_piece(input int probe_row);
        int row, col, kind, new_kind, drop_col;
        row_t data;
        logic err;
        read_status(row, col, kind);
        drop_col = col;
        wait_gravity_step();
        @(negedge frame_clk);
        keycode = KEY_DROP;
        repeat (3) @(negedge frame_clk);
        keycode = 8'h00;
        if (probe_row >= 0) begin
            apb_access(1'b0, apb_addr_t'(probe_row), data, err);
            check_value(data, expected_row(probe_row), "row read during a drop");
        end
        do read_status(row, col, new_kind); while (new_kind == kind);
        check_value(new_kind, (kind + 1) % 6, "spawned kind");
        check_value(col, 3, "spawn column");
        if (row > 1) begin
            $display("CHECK FAILED at %0t ns: spawn row %0d, expected 0 or 1", $time, row);
            $display("** FAIL **");
            $fatal(1, "bad spawn row");
        end
        check_value(next_block, (new_kind + 1) % 6, "next_block after spawn");
        lock_model(kind, drop_col);
        compare_grid();
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        int row, col, kind;
        read_status(row, col, kind);
        check_value(kind, 0, "kind after reset");
        check_value(col, 3, "column after reset");
        check_value(row, 0, "row after reset");
        check_value(next_block, 1, "next_block after reset");
        compare_grid();
    endtask

    task automatic test_side_moves();
        int row, col, kind;
        move_to(0);
        press_key(KEY_LEFT, 3);
        read_status(row, col, kind);
        check_value(col, 0, "left move at the wall");
        // held across a gravity step, counts once
        press_key(KEY_RIGHT, 40);
        read_status(row, col, kind);
        check_value(col, 1, "column after a held right key");
    endtask

    task automatic test_gravity();
        int row0, row, col, kind, start;
        for (int i = 0; i < 4; i++) begin
            read_status(row0, col, kind);
            start = cycle_count;
            do read_status(row, col, kind); while (row == row0);
            if (cycle_count - start > 64) begin
                $display("gravity step took more than 64 frames");
                $display("** FAIL **");
                $fatal(1, "gravity too slow");
            end
            check_value(row, row0 + 1, "row after a gravity step");
        end
    endtask

    task automatic test_bad_access();
        row_t data;
        logic err;
        apb_access(1'b1, 5'd0, data, err);
        check_value(err, 1, "pslverr on a write");
        apb_access(1'b0, 5'd22, data, err);
        check_value(err, 1, "pslverr on address 22");
    endtask

    initial begin
        rnd = $urandom(RAND_SEED);
        keycode = 8'h00;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        model_score = 0;
        for (int r = 0; r < GRID_ROWS; r++) begin
            for (int c = 0; c < GRID_COLS; c++) begin
                model_grid[r][c] = 7;
            end
        end
        @(negedge reset);
        @(negedge frame_clk);

        test_reset_state();
        test_side_moves();
        test_gravity();
        // I into the left corner
        move_to(0);
        drop_piece(-1);
        // J and L complete the bottom row
        move_to(3);
        drop_piece(-1);
        move_to(6);
        drop_piece(-1);
        check_value(score, 1, "score after the first full row");
        move_to(0);
        drop_piece(-1);
        move_to(5);
        drop_piece(-1);
        move_to(3);
        drop_piece(-1);
        test_bad_access();
        drop_piece(19);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/frame_clock.sv
/* frame clock and reset generator for the testbench */
`timescale 1ns/1ns
`default_nettype none

module frame_clock (
    output logic frame_clk,
    output logic reset
);

    initial begin
        frame_clk = 1'b0;
        forever #20 frame_clk = ~frame_clk;
    end

    // reset held for 8 frames, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge frame_clk);
        @(negedge frame_clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- logic/tetris_top.sv
/* top level, row memory, arbiter, piece controller, row clearer, APB port */
`timescale 1ns/1ns
`default_nettype none

module tetris_top import tetris_pkg::*; (
    input  logic       frame_clk,
    input  logic       reset,
    input  logic [7:0] keycode,
    output score_t     score,
    output kind_t      next_block,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  row_t       pwdata,
    output row_t       prdata,
    output logic       pready,
    output logic       pslverr
);

    // ----------------------------------------
    // memory bus
    // ----------------------------------------
    logic [2:0]  gnt;
    row_idx_t    mem_addr;
    logic        mem_wr_en;
    row_t        mem_wdata;
    row_t        rd_row;

    logic        clear_req, piece_req, host_req;
    row_idx_t    clear_addr, piece_addr, host_addr;
    logic        clear_wr_en, piece_wr_en;
    row_t        clear_wdata, piece_wdata;

    logic        clear_start, clear_done;
    logic [11:0] status;

    grid_rows u_rows (
        .frame_clk (frame_clk),
        .reset     (reset),
        .addr      (mem_addr),
        .wr_en     (mem_wr_en),
        .wdata     (mem_wdata),
        .rd_row    (rd_row)
    );

    grid_arbiter u_arb (
        .frame_clk   (frame_clk),
        .reset       (reset),
        .req         ({host_req, piece_req, clear_req}),
        .clear_addr  (clear_addr),
        .piece_addr  (piece_addr),
        .host_addr   (host_addr),
        .clear_wr_en (clear_wr_en),
        .piece_wr_en (piece_wr_en),
        .clear_wdata (clear_wdata),
        .piece_wdata (piece_wdata),
        .gnt         (gnt),
        .addr        (mem_addr),
        .wr_en       (mem_wr_en),
        .wdata       (mem_wdata)
    );

    piece_ctrl u_piece (
        .frame_clk   (frame_clk),
        .reset       (reset),
        .keycode     (keycode),
        .gnt         (gnt[REQ_PIECE]),
        .rd_row      (rd_row),
        .req         (piece_req),
        .addr        (piece_addr),
        .wr_en       (piece_wr_en),
        .wdata       (piece_wdata),
        .clear_start (clear_start),
        .clear_done  (clear_done),
        .next_block  (next_block),
        .status      (status)
    );

    row_clear u_clear (
        .frame_clk   (frame_clk),
        .reset       (reset),
        .clear_start (clear_start),
        .gnt         (gnt[REQ_CLEAR]),
        .rd_row      (rd_row),
        .req         (clear_req),
        .addr        (clear_addr),
        .wr_en       (clear_wr_en),
        .wdata       (clear_wdata),
        .clear_done  (clear_done),
        .score       (score)
    );

    apb_grid_port u_apb (
        .frame_clk (frame_clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .gnt       (gnt[REQ_HOST]),
        .rd_row    (rd_row),
        .req       (host_req),
        .addr      (host_addr),
        .score     (score),
        .status    (status)
    );

endmodule

`default_nettype wire

//--- logic/apb_grid_port.sv
/* read-only APB slave for grid rows, score and piece status */
`timescale 1ns/1ns
`default_nettype none

module apb_grid_port import tetris_pkg::*; (
    input  logic        frame_clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  row_t        pwdata,
    output row_t        prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        gnt,
    input  row_t        rd_row,
    output logic        req,
    output row_idx_t    addr,
    input  score_t      score,
    input  logic [11:0] status
);

    logic direct;
    logic row_ready;

    // writes, score, status and bad addresses need no memory access
    assign direct = pwrite || paddr >= ADDR_SCORE;
    assign req = psel && penable && !direct && !row_ready;
    assign addr = row_idx_t'(paddr);
    assign pready = psel && penable && (direct || row_ready);
    assign pslverr = pready && (pwrite || paddr > ADDR_STATUS);

    always_comb begin
        if (paddr == ADDR_SCORE) begin
            prdata = row_t'(score);
        end else if (paddr == ADDR_STATUS) begin
            prdata = row_t'(status);
        end else if (paddr < GRID_ROWS) begin
            prdata = rd_row;
        end else begin
            prdata = '0;
        end
    end

    // rd_row is valid the cycle after the grant
    always_ff @(posedge frame_clk) begin
        if (reset) begin
            row_ready <= 1'b0;
        end else begin
            row_ready <= req && gnt;
        end
    end

    // an access phase always follows a cycle with psel high
    a_pready_in_access: assert property (@(posedge frame_clk) disable iff (reset)
        pready |-> psel && penable && $past(psel))
        else $error("pready outside an access phase");

    a_wdata_known: assert property (@(posedge frame_clk) disable iff (reset)
        psel && pwrite |-> !$isunknown(pwdata))
        else $error("host write with unknown data");

endmodule

`default_nettype wire

//--- logic/row_clear.sv
/* full-row scan from the bottom, row shift-down and score count */
`timescale 1ns/1ns
`default_nettype none

module row_clear import tetris_pkg::*; (
    input  logic     frame_clk,
    input  logic     reset,
    input  logic     clear_start,
    input  logic     gnt,
    input  row_t     rd_row,
    output logic     req,
    output row_idx_t addr,
    output logic     wr_en,
    output row_t     wdata,
    output logic     clear_done,
    output score_t   score
);

    typedef enum logic [2:0] {CL_IDLE, CL_READ, CL_CHECK, CL_SRC, CL_COPY, CL_TOP} clr_state_t;

    clr_state_t state;
    row_idx_t   cur;
    row_idx_t   dst;
    logic       row_full;

    always_comb begin
        row_full = 1'b1;
        for (int c = 0; c < GRID_COLS; c++) begin
            if (rd_row[c*3 +: 3] == CELL_EMPTY) begin
                row_full = 1'b0;
            end
        end
    end

    // top priority, so every request is granted at once
    // and rd_row can go straight back as write data
    always_comb begin
        req = 1'b0;
        wr_en = 1'b0;
        addr = cur;
        wdata = rd_row;
        case (state)
            CL_READ: req = 1'b1;
            CL_SRC: begin
                req = 1'b1;
                addr = dst - 5'd1;
            end
            CL_COPY: begin
                req = 1'b1;
                wr_en = 1'b1;
                addr = dst;
            end
            CL_TOP: begin
                req = 1'b1;
                wr_en = 1'b1;
                addr = '0;
                wdata = ROW_EMPTY;
            end
            default: ;
        endcase
    end

    always_ff @(posedge frame_clk) begin
        if (reset) begin
            state <= CL_IDLE;
            cur <= '0;
            dst <= '0;
            score <= '0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            case (state)
                CL_IDLE: begin
                    if (clear_start) begin
                        cur <= row_idx_t'(GRID_ROWS - 1);
                        state <= CL_READ;
                    end
                end
                CL_READ: if (gnt) state <= CL_CHECK;
                CL_CHECK: begin
                    if (row_full) begin
                        score <= score + 10'd1;
                        dst <= cur;
                        state <= (cur == '0) ? CL_TOP : CL_SRC;
                    end else if (cur == '0) begin
                        clear_done <= 1'b1;
                        state <= CL_IDLE;
                    end else begin
                        cur <= cur - 5'd1;
                        state <= CL_READ;
                    end
                end
                CL_SRC: if (gnt) state <= CL_COPY;
                CL_COPY: begin
                    if (gnt) begin
                        if (dst == 5'd1) begin
                            state <= CL_TOP;
                        end else begin
                            dst <= dst - 5'd1;
                            state <= CL_SRC;
                        end
                    end
                end
                // rescan the same row after the shift
                CL_TOP: if (gnt) state <= CL_READ;
                default: state <= CL_IDLE;
            endcase
        end
    end

    a_start_when_idle: assert property (@(posedge frame_clk) disable iff (reset)
        clear_start |-> state == CL_IDLE)
        else $error("clear_start during a running scan");

endmodule

`default_nettype wire

//--- logic/piece_ctrl.sv
/* active piece registers, gravity, key edges, collision, lock and spawn */
`timescale 1ns/1ns
`default_nettype none

module piece_ctrl import tetris_pkg::*; (
    input  logic        frame_clk,
    input  logic        reset,
    input  logic [7:0]  keycode,
    input  logic        gnt,
    input  row_t        rd_row,
    output logic        req,
    output row_idx_t    addr,
    output logic        wr_en,
    output row_t        wdata,
    output logic        clear_start,
    input  logic        clear_done,
    output kind_t       next_block,
    output logic [11:0] status
);

    typedef enum logic [2:0] {IDLE, READ, DECIDE, LOCK, WAIT_CLEAR, SPAWN} state_t;

    state_t     state;
    kind_t      kind;
    col_idx_t   bx;
    row_idx_t   by;
    logic       mv_left, mv_right, mv_down, locking;
    logic       phase, rd_wait;
    logic       drop_pend, grav_pend;
    logic [4:0] grav_cnt;
    logic [7:0] key_prev;
    row_t       row_buf [2];
    row_t       lock_row [2];
    logic [7:0] mask;
    logic       blocked, cols_ok, key_edge, grav_tick;
    int         new_col;

    assign mask = piece_mask(kind);
    assign key_edge = (keycode != key_prev);
    assign grav_tick = (grav_cnt == 5'(GRAVITY_FRAMES - 1));
    assign next_block = (kind == KIND_T) ? KIND_I : kind_t'(kind + 3'd1);
    assign status = {by, bx, 3'(kind)};

    // ----------------------------------------
    // collision test of the shifted mask
    // ----------------------------------------
    always_comb begin
        new_col = int'(bx) + int'(mv_right) - int'(mv_left);
        blocked = (new_col < 0);
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (mask[r*4+c]) begin
                    if (new_col + c < 0 || new_col + c >= GRID_COLS) begin
                        blocked = 1'b1;
                    end else if (int'(by) + int'(mv_down) + r >= GRID_ROWS) begin
                        blocked = 1'b1;
                    end else if (row_buf[r][(new_col+c)*3 +: 3] != CELL_EMPTY) begin
                        blocked = 1'b1;
                    end
                end
            end
        end
    end

    // rows y and y+1 with the piece merged in
    always_comb begin
        for (int r = 0; r < 2; r++) begin
            lock_row[r] = row_buf[r];
            for (int c = 0; c < 4; c++) begin
                if (mask[r*4+c] && int'(bx) + c < GRID_COLS) begin
                    lock_row[r][(int'(bx)+c)*3 +: 3] = cell_t'(kind);
                end
            end
        end
    end

    always_comb begin
        cols_ok = 1'b1;
        for (int c = 0; c < 4; c++) begin
            if ((mask[c] || mask[c+4]) && int'(bx) + c >= GRID_COLS) begin
                cols_ok = 1'b0;
            end
        end
    end

    always_comb begin
        req = 1'b0;
        wr_en = 1'b0;
        addr = by;
        wdata = lock_row[phase];
        case (state)
            READ: begin
                req = !rd_wait;
                addr = by + row_idx_t'(mv_down) + row_idx_t'(phase);
            end
            LOCK: begin
                req = 1'b1;
                wr_en = 1'b1;
                addr = by + row_idx_t'(phase);
            end
            default: ;
        endcase
    end

    always_ff @(posedge frame_clk) begin
        if (state == READ && rd_wait) begin
            row_buf[phase] <= rd_row;
        end
    end

    // ----------------------------------------
    // piece FSM
    // ----------------------------------------
    always_ff @(posedge frame_clk) begin
        if (reset) begin
            state <= IDLE;
            kind <= KIND_I;
            bx <= SPAWN_COL;
            by <= '0;
            {mv_left, mv_right, mv_down, locking} <= 4'b0000;
            phase <= 1'b0;
            rd_wait <= 1'b0;
            drop_pend <= 1'b0;
            grav_pend <= 1'b0;
            grav_cnt <= '0;
            key_prev <= 8'h00;
            clear_start <= 1'b0;
        end else begin
            grav_cnt <= grav_cnt + 5'd1;
            key_prev <= keycode;
            clear_start <= 1'b0;
            if (grav_tick) begin
                grav_pend <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (drop_pend || grav_pend || grav_tick) begin
                        {mv_left, mv_right, mv_down} <= 3'b001;
                        grav_pend <= 1'b0;
                        state <= READ;
                    end else if (key_edge && keycode == KEY_LEFT) begin
                        {mv_left, mv_right, mv_down} <= 3'b100;
                        state <= READ;
                    end else if (key_edge && keycode == KEY_RIGHT) begin
                        {mv_left, mv_right, mv_down} <= 3'b010;
                        state <= READ;
                    end else if (key_edge && keycode == KEY_DROP) begin
                        drop_pend <= 1'b1;
                        {mv_left, mv_right, mv_down} <= 3'b001;
                        state <= READ;
                    end
                end
                READ: begin
                    if (rd_wait) begin
                        rd_wait <= 1'b0;
                        phase <= ~phase;
                        if (phase) begin
                            state <= locking ? LOCK : DECIDE;
                        end
                    end else if (gnt) begin
                        rd_wait <= 1'b1;
                    end
                end
                DECIDE: begin
                    if (!blocked) begin
                        bx <= col_idx_t'(new_col);
                        by <= by + row_idx_t'(mv_down);
                        state <= IDLE;
                    end else if (mv_down) begin
                        // reread rows y and y+1 for the lock
                        locking <= 1'b1;
                        mv_down <= 1'b0;
                        state <= READ;
                    end else begin
                        state <= IDLE;
                    end
                end
                LOCK: begin
                    if (gnt) begin
                        phase <= ~phase;
                        if (phase) begin
                            locking <= 1'b0;
                            clear_start <= 1'b1;
                            state <= WAIT_CLEAR;
                        end
                    end
                end
                WAIT_CLEAR: begin
                    if (clear_done) begin
                        state <= SPAWN;
                    end
                end
                SPAWN: begin
                    kind <= next_block;
                    bx <= SPAWN_COL;
                    by <= '0;
                    drop_pend <= 1'b0;
                    grav_pend <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_cols_in_grid: assert property (@(posedge frame_clk) disable iff (reset)
        cols_ok)
        else $error("active piece covers a column outside the grid");

endmodule

`default_nettype wire

//--- logic/grid_arbiter.sv
/* fixed-priority arbiter for the row memory, clearer over piece over host */
`timescale 1ns/1ns
`default_nettype none

module grid_arbiter import tetris_pkg::*; (
    input  logic       frame_clk,
    input  logic       reset,
    input  logic [2:0] req,
    input  row_idx_t   clear_addr,
    input  row_idx_t   piece_addr,
    input  row_idx_t   host_addr,
    input  logic       clear_wr_en,
    input  logic       piece_wr_en,
    input  row_t       clear_wdata,
    input  row_t       piece_wdata,
    output logic [2:0] gnt,
    output row_idx_t   addr,
    output logic       wr_en,
    output row_t       wdata
);

    always_comb begin
        gnt = 3'b000;
        if (req[REQ_CLEAR]) begin
            gnt[REQ_CLEAR] = 1'b1;
        end else if (req[REQ_PIECE]) begin
            gnt[REQ_PIECE] = 1'b1;
        end else if (req[REQ_HOST]) begin
            gnt[REQ_HOST] = 1'b1;
        end
    end

    // forward the winner, host is read only
    assign addr = gnt[REQ_CLEAR] ? clear_addr :
                  gnt[REQ_PIECE] ? piece_addr : host_addr;
    assign wr_en = (gnt[REQ_CLEAR] & clear_wr_en) | (gnt[REQ_PIECE] & piece_wr_en);
    assign wdata = gnt[REQ_CLEAR] ? clear_wdata : piece_wdata;

    a_gnt_onehot: assert property (@(posedge frame_clk) disable iff (reset)
        $onehot0(gnt))
        else $error("more than one row memory grant");

    // a host cycle must not hide a write from another requester
    a_host_no_write: assert property (@(posedge frame_clk) disable iff (reset)
        gnt[REQ_HOST] |-> !clear_wr_en && !piece_wr_en)
        else $error("write pending while the host holds the row memory");

endmodule

`default_nettype wire

//--- logic/grid_rows.sv
/* row memory of locked cells, single read/write port, registered read */
`timescale 1ns/1ns
`default_nettype none

module grid_rows import tetris_pkg::*; (
    input  logic     frame_clk,
    input  logic     reset,
    input  row_idx_t addr,
    input  logic     wr_en,
    input  row_t     wdata,
    output row_t     rd_row
);

    row_t rows [GRID_ROWS];

    always_ff @(posedge frame_clk) begin
        if (reset) begin
            for (int r = 0; r < GRID_ROWS; r++) begin
                rows[r] <= ROW_EMPTY;
            end
        end else if (wr_en) begin
            rows[addr] <= wdata;
        end
    end

    // rows past the floor read as empty
    always_ff @(posedge frame_clk) begin
        rd_row <= (addr < GRID_ROWS) ? rows[addr] : ROW_EMPTY;
    end

endmodule

`default_nettype wire

//--- logic/tetris_pkg.sv
/* shared grid sizes, cell and row types, piece kinds and masks,
   key codes, APB address map and timing constants */
`default_nettype none

package tetris_pkg;

    // ----------------------------------------
    // grid geometry
    // ----------------------------------------
    localparam int GRID_ROWS = 20;
    localparam int GRID_COLS = 10;

    typedef logic [2:0] cell_t;
    typedef logic [29:0] row_t;
    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    localparam cell_t CELL_EMPTY = 3'd7;
    localparam row_t ROW_EMPTY = {GRID_COLS{CELL_EMPTY}};

    typedef enum logic [2:0] {
        KIND_I = 3'd0,
        KIND_J = 3'd1,
        KIND_L = 3'd2,
        KIND_O = 3'd3,
        KIND_S = 3'd4,
        KIND_T = 3'd5
    } kind_t;

    // box origin at spawn, row is always 0
    localparam col_idx_t SPAWN_COL = 4'd3;
    localparam int GRAVITY_FRAMES = 32;

    localparam logic [7:0] KEY_LEFT = 8'h04;
    localparam logic [7:0] KEY_RIGHT = 8'h07;
    localparam logic [7:0] KEY_DROP = 8'h16;

    typedef logic [9:0] score_t;

    typedef logic [4:0] apb_addr_t;
    localparam apb_addr_t ADDR_SCORE = 5'd20;
    localparam apb_addr_t ADDR_STATUS = 5'd21;

    // index into the arbiter req and gnt vectors
    typedef enum logic [1:0] {
        REQ_CLEAR = 2'd0,
        REQ_PIECE = 2'd1,
        REQ_HOST = 2'd2
    } requester_t;

    // 2x4 box, top row in bits 3..0, bottom row in bits 7..4
    function automatic logic [7:0] piece_mask(input kind_t kind);
        case (kind)
            KIND_I: piece_mask = 8'hF0;
            KIND_J: piece_mask = 8'hE2;
            KIND_L: piece_mask = 8'hE8;
            KIND_O: piece_mask = 8'h66;
            KIND_S: piece_mask = 8'h6C;
            KIND_T: piece_mask = 8'hE4;
            default: piece_mask = 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire
